/* hdl/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define INSTR_W     32
`define OP_W        6
`define FUNCT_W     6
`define REG_W       5
`define SHAMT_W     5
`define IMM_W       16      // Overlays rd, shamt and funct

`define CLASS_W     4
`define ALU_FUNC_W  3
`define SFT_FUNC_W  2
`define BRANCH_W    3
`define JUMP_W      2
`define SIZE_W      2
`define REGDST_W    2

`endif

/* hdl/isa_pkg.sv */
`include "cpu_defines.svh"

package isa_pkg;

    typedef enum logic [`OP_W-1:0] {
        OP_SPECIAL = 6'b000000, OP_REGIMM = 6'b000001, OP_J     = 6'b000010,
        OP_JAL     = 6'b000011, OP_BEQ    = 6'b000100, OP_BNE   = 6'b000101,
        OP_BLEZ    = 6'b000110, OP_BGTZ   = 6'b000111, OP_ADDI  = 6'b001000,
        OP_ADDIU   = 6'b001001, OP_SLTI   = 6'b001010, OP_SLTIU = 6'b001011,
        OP_ANDI    = 6'b001100, OP_ORI    = 6'b001101, OP_XORI  = 6'b001110,
        OP_LUI     = 6'b001111, OP_LB     = 6'b100000, OP_LH    = 6'b100001,
        OP_LW      = 6'b100011, OP_LBU    = 6'b100100, OP_LHU   = 6'b100101,
        OP_SB      = 6'b101000, OP_SH     = 6'b101001, OP_SW    = 6'b101011
    } opcode_t;

    typedef enum logic [`FUNCT_W-1:0] {
        FN_SLL     = 6'b000000, FN_SRL    = 6'b000010, FN_SRA   = 6'b000011,
        FN_SLLV    = 6'b000100, FN_SRLV   = 6'b000110, FN_SRAV  = 6'b000111,
        FN_JR      = 6'b001000, FN_JALR   = 6'b001001, FN_SYSCALL = 6'b001100,
        FN_BREAK   = 6'b001101, FN_SYNC   = 6'b001111, FN_ADD   = 6'b100000,
        FN_ADDU    = 6'b100001, FN_SUB    = 6'b100010, FN_SUBU  = 6'b100011,
        FN_AND     = 6'b100100, FN_OR     = 6'b100101, FN_XOR   = 6'b100110,
        FN_NOR     = 6'b100111, FN_SLT    = 6'b101010, FN_SLTU  = 6'b101011
    } funct_t;

    // Carried in the rt field under REGIMM
    typedef enum logic [`REG_W-1:0] {
        RI_BLTZ = 5'b00000, RI_BGEZ = 5'b00001, RI_BLTZAL = 5'b10000, RI_BGEZAL = 5'b10001
    } regimm_t;

    typedef struct packed {
        opcode_t             op;
        logic [`REG_W-1:0]   rs;
        logic [`REG_W-1:0]   rt;
        logic [`REG_W-1:0]   rd;
        logic [`SHAMT_W-1:0] shamt;
        funct_t              funct;
    } instr_t;

    typedef enum logic [`CLASS_W-1:0] {
        C_RALU, C_RSHIFT, C_RSHIFTV, C_IALU, C_LUI, C_LOAD,
        C_STORE, C_BRANCH, C_JUMP, C_TRAP, C_NOP, C_RESERVED
    } instr_class_t;

endpackage

/* hdl/ctrl_pkg.sv */
`include "cpu_defines.svh"

package ctrl_pkg;

    typedef enum logic [`ALU_FUNC_W-1:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND, ALU_NOR, ALU_OR, ALU_XOR
    } alu_func_t;

    typedef enum logic [`SFT_FUNC_W-1:0] {
        SFT_LUI, SFT_SLL, SFT_SRA, SFT_SRL
    } sft_func_t;

    typedef enum logic {
        OUT_ALU, OUT_SFT
    } out_sel_t;

    typedef enum logic [`BRANCH_W-1:0] {
        BR_BEQ, BR_BNE, BR_BGEZ, BR_BGTZ, BR_BLEZ, BR_BLTZ, BR_BGEZAL, BR_BLTZAL
    } branch_t;

    typedef enum logic [`JUMP_W-1:0] {
        JMP_J, JMP_JR, JMP_JAL, JMP_JALR
    } jump_t;

    typedef enum logic [`SIZE_W-1:0] {
        SZ_BYTE, SZ_HALF, SZ_WORD
    } mem_size_t;

    typedef enum logic [`REGDST_W-1:0] {
        DST_RT, DST_RD, DST_RA    // RA is register 31
    } regdst_t;

    typedef struct packed {
        alu_func_t alu_func;
        sft_func_t sft_func;
        out_sel_t  out_sel;
        logic      alu_srcb_rt;
        logic      sft_srcb_rs;
        logic      imm_sign;
        logic      intovf_en;
    } exe_ctrl_t;

    typedef struct packed {
        logic      memreq;
        logic      memwr;
        mem_size_t size;
        logic      rdata_sign;
        logic      memtoreg;
    } mem_ctrl_t;

    typedef struct packed {
        logic    isbranch;
        branch_t branch;
        logic    isjump;
        jump_t   jump;
        logic    link;
        logic    brk;
        logic    syscall;
    } flow_ctrl_t;

    typedef struct packed {
        logic    regwrite;
        regdst_t regdst;
        logic    reserved;
    } wb_ctrl_t;

endpackage

/* hdl/instr_classifier.sv */
`include "cpu_defines.svh"

module instr_classifier
(
    input  logic [`INSTR_W-1:0]   instr,
    output isa_pkg::instr_t       fields,
    output isa_pkg::instr_class_t iclass,
    output ctrl_pkg::wb_ctrl_t    wb
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    assign fields = instr_t'(instr);

    always_comb
    begin
        case (fields.op)
            OP_SPECIAL:
            begin
                case (fields.funct)
                    FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT,
                    FN_SLTU, FN_AND, FN_OR, FN_NOR, FN_XOR: iclass = C_RALU;
                    FN_SLL, FN_SRL, FN_SRA:    iclass = C_RSHIFT;
                    FN_SLLV, FN_SRLV, FN_SRAV: iclass = C_RSHIFTV;
                    FN_JR, FN_JALR:            iclass = C_JUMP;
                    FN_BREAK, FN_SYSCALL:      iclass = C_TRAP;
                    FN_SYNC:                   iclass = C_NOP;     // Treated as no-op
                    default:                   iclass = C_RESERVED;
                endcase
            end
            OP_REGIMM:
            begin
                case (fields.rt)
                    RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL: iclass = C_BRANCH;
                    default:                                iclass = C_RESERVED;
                endcase
            end
            OP_J, OP_JAL:                          iclass = C_JUMP;
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ:      iclass = C_BRANCH;
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
            OP_ANDI, OP_ORI, OP_XORI:              iclass = C_IALU;
            OP_LUI:                                iclass = C_LUI;
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU:   iclass = C_LOAD;
            OP_SB, OP_SH, OP_SW:                   iclass = C_STORE;
            default:                               iclass = C_RESERVED;
        endcase
    end

    always_comb
    begin
        wb = '0;
        case (iclass)
            C_RALU, C_RSHIFT, C_RSHIFTV:
            begin
                wb.regwrite = 1'b1;
                wb.regdst   = DST_RD;
            end
            C_IALU, C_LUI, C_LOAD:
            begin
                wb.regwrite = 1'b1;
                wb.regdst   = DST_RT;
            end
            C_JUMP:
            begin
                if (fields.op == OP_JAL)
                begin
                    wb.regwrite = 1'b1;
                    wb.regdst   = DST_RA;
                end
                else if (fields.op == OP_SPECIAL && fields.funct == FN_JALR)
                begin
                    wb.regwrite = 1'b1;
                    wb.regdst   = DST_RD;    // Link register named by rd
                end
            end
            C_BRANCH:
            begin
                if (fields.op == OP_REGIMM && (fields.rt == RI_BGEZAL || fields.rt == RI_BLTZAL))
                begin
                    wb.regwrite = 1'b1;
                    wb.regdst   = DST_RA;
                end
            end
            C_RESERVED: wb.reserved = 1'b1;
            default: ;
        endcase
    end

endmodule

/* hdl/exe_decoder.sv */
module exe_decoder
(
    input  isa_pkg::instr_class_t iclass,
    input  isa_pkg::instr_t       fields,
    output ctrl_pkg::exe_ctrl_t   exe
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    always_comb
    begin
        exe = '0;
        case (iclass)
            C_RALU:
            begin
                exe.alu_srcb_rt = 1'b1;
                exe.intovf_en   = (fields.funct == FN_ADD) || (fields.funct == FN_SUB);
                case (fields.funct)
                    FN_SUB, FN_SUBU: exe.alu_func = ALU_SUB;
                    FN_SLT:          exe.alu_func = ALU_SLT;
                    FN_SLTU:         exe.alu_func = ALU_SLTU;
                    FN_AND:          exe.alu_func = ALU_AND;
                    FN_NOR:          exe.alu_func = ALU_NOR;
                    FN_OR:           exe.alu_func = ALU_OR;
                    FN_XOR:          exe.alu_func = ALU_XOR;
                    default:         exe.alu_func = ALU_ADD;
                endcase
            end
            C_RSHIFT, C_RSHIFTV:
            begin
                exe.out_sel     = OUT_SFT;
                exe.sft_srcb_rs = (iclass == C_RSHIFTV);    // Amount from rs
                case (fields.funct)
                    FN_SRA, FN_SRAV: exe.sft_func = SFT_SRA;
                    FN_SRL, FN_SRLV: exe.sft_func = SFT_SRL;
                    default:         exe.sft_func = SFT_SLL;
                endcase
            end
            C_IALU:
            begin
                exe.imm_sign  = fields.op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU};
                exe.intovf_en = (fields.op == OP_ADDI);
                case (fields.op)
                    OP_SLTI:  exe.alu_func = ALU_SLT;
                    OP_SLTIU: exe.alu_func = ALU_SLTU;
                    OP_ANDI:  exe.alu_func = ALU_AND;
                    OP_ORI:   exe.alu_func = ALU_OR;
                    OP_XORI:  exe.alu_func = ALU_XOR;
                    default:  exe.alu_func = ALU_ADD;
                endcase
            end
            C_LUI:
            begin
                exe.out_sel  = OUT_SFT;
                exe.sft_func = SFT_LUI;
            end
            C_LOAD, C_STORE:
            begin
                exe.alu_func = ALU_ADD;    // Base plus offset
                exe.imm_sign = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* hdl/mem_decoder.sv */
module mem_decoder
(
    input  isa_pkg::instr_class_t iclass,
    input  isa_pkg::instr_t       fields,
    output ctrl_pkg::mem_ctrl_t   mem
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    always_comb
    begin
        mem = '0;
        if (iclass == C_LOAD || iclass == C_STORE)
        begin
            mem.memreq     = 1'b1;
            mem.memwr      = (iclass == C_STORE);
            mem.memtoreg   = (iclass == C_LOAD);
            mem.rdata_sign = fields.op inside {OP_LB, OP_LH, OP_LW};
            case (fields.op)
                OP_LB, OP_LBU, OP_SB: mem.size = SZ_BYTE;
                OP_LH, OP_LHU, OP_SH: mem.size = SZ_HALF;
                default:              mem.size = SZ_WORD;
            endcase
        end
    end

endmodule

/* hdl/flow_decoder.sv */
module flow_decoder
(
    input  isa_pkg::instr_class_t iclass,
    input  isa_pkg::instr_t       fields,
    output ctrl_pkg::flow_ctrl_t  flow
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    always_comb
    begin
        flow = '0;
        case (iclass)
            C_BRANCH:
            begin
                flow.isbranch = 1'b1;
                case (fields.op)
                    OP_BEQ:  flow.branch = BR_BEQ;
                    OP_BNE:  flow.branch = BR_BNE;
                    OP_BGTZ: flow.branch = BR_BGTZ;
                    OP_BLEZ: flow.branch = BR_BLEZ;
                    default:
                    begin
                        case (fields.rt)    // REGIMM group
                            RI_BGEZ:   flow.branch = BR_BGEZ;
                            RI_BGEZAL: flow.branch = BR_BGEZAL;
                            RI_BLTZAL: flow.branch = BR_BLTZAL;
                            default:   flow.branch = BR_BLTZ;
                        endcase
                    end
                endcase
                flow.link = (flow.branch == BR_BGEZAL) || (flow.branch == BR_BLTZAL);
            end
            C_JUMP:
            begin
                flow.isjump = 1'b1;
                if (fields.op == OP_J)
                    flow.jump = JMP_J;
                else if (fields.op == OP_JAL)
                    flow.jump = JMP_JAL;
                else if (fields.funct == FN_JALR)
                    flow.jump = JMP_JALR;
                else
                    flow.jump = JMP_JR;
                flow.link = (flow.jump == JMP_JAL) || (flow.jump == JMP_JALR);
            end
            C_TRAP:
            begin
                flow.brk     = (fields.funct == FN_BREAK);
                flow.syscall = (fields.funct == FN_SYSCALL);
            end
            default: ;
        endcase
    end

endmodule

/* hdl/ctrl_stage_reg.sv */
module ctrl_stage_reg #(
    parameter type payload_t = logic
)
(
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk)
    begin
        if (rst || flush)    // Flush wins over stall
            q <= '0;
        else if (!stall)
            q <= d;
    end

endmodule

/* hdl/decode_stage.sv */
`include "cpu_defines.svh"

module decode_stage
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`INSTR_W-1:0]  instr,
    input  logic                 stall,
    input  logic                 flush,
    output ctrl_pkg::exe_ctrl_t  exe,
    output ctrl_pkg::mem_ctrl_t  mem,
    output ctrl_pkg::flow_ctrl_t flow,
    output ctrl_pkg::wb_ctrl_t   wb
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    instr_t       fields;
    instr_class_t iclass;
    exe_ctrl_t    exe_d;
    mem_ctrl_t    mem_d;
    flow_ctrl_t   flow_d;
    wb_ctrl_t     wb_d;

    instr_classifier classifier_i (.instr(instr), .fields(fields), .iclass(iclass), .wb(wb_d));

    exe_decoder  exe_dec_i  (.iclass(iclass), .fields(fields), .exe(exe_d));
    mem_decoder  mem_dec_i  (.iclass(iclass), .fields(fields), .mem(mem_d));
    flow_decoder flow_dec_i (.iclass(iclass), .fields(fields), .flow(flow_d));

    ctrl_stage_reg #(.payload_t(exe_ctrl_t)) exe_reg_i (
        .clk(clk), .rst(rst), .stall(stall), .flush(flush), .d(exe_d), .q(exe)
    );

    ctrl_stage_reg #(.payload_t(mem_ctrl_t)) mem_reg_i (
        .clk(clk), .rst(rst), .stall(stall), .flush(flush), .d(mem_d), .q(mem)
    );

    ctrl_stage_reg #(.payload_t(flow_ctrl_t)) flow_reg_i (
        .clk(clk), .rst(rst), .stall(stall), .flush(flush), .d(flow_d), .q(flow)
    );

    ctrl_stage_reg #(.payload_t(wb_ctrl_t)) wb_reg_i (
        .clk(clk), .rst(rst), .stall(stall), .flush(flush), .d(wb_d), .q(wb)
    );

endmodule

/* test/decode_stage_checker.sv */
module decode_stage_checker
(
    input logic                 clk,
    input logic                 rst,
    input logic                 flush,
    input ctrl_pkg::exe_ctrl_t  exe,
    input ctrl_pkg::mem_ctrl_t  mem,
    input ctrl_pkg::flow_ctrl_t flow,
    input ctrl_pkg::wb_ctrl_t   wb
);
    import ctrl_pkg::*;

    int memwr_fails    = 0;
    int reserved_fails = 0;
    int link_fails     = 0;
    int flush_fails    = 0;
    int fail_count;

    assign fail_count = memwr_fails + reserved_fails + link_fails + flush_fails;

    assert property (@(posedge clk) disable iff (rst) mem.memwr |-> mem.memreq)
    else
    begin
        memwr_fails++;
        $error("memory write raised without a memory request");
    end

    assert property (@(posedge clk) disable iff (rst) wb.reserved |-> !wb.regwrite)
    else
    begin
        reserved_fails++;
        $error("reserved instruction writes a register");
    end

    // JALR links through rd and every other link through register 31
    assert property (@(posedge clk) disable iff (rst)
                     flow.link |-> wb.regwrite && (wb.regdst == DST_RA ||
                                   (flow.jump == JMP_JALR && wb.regdst == DST_RD)))
    else
    begin
        link_fails++;
        $error("link without a write to the link register");
    end

    assert property (@(posedge clk) flush |=> {exe, mem, flow, wb} == '0)
    else
    begin
        flush_fails++;
        $error("control word not cleared after flush");
    end

endmodule

/* test/decode_stage_tb.sv */
`include "cpu_defines.svh"

module decode_stage_tb;
    import ctrl_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int SEED         = 61079;
    localparam int RALU_CYCLES  = 150;
    localparam int IMM_CYCLES   = 80;
    localparam int MEM_CYCLES   = 80;
    localparam int FLOW_CYCLES  = 100;
    localparam int RSV_CYCLES   = 120;
    localparam int MIX_CYCLES   = 300;
    localparam int TOTAL_CYCLES = 2 + RALU_CYCLES + IMM_CYCLES + MEM_CYCLES + FLOW_CYCLES
                                + RSV_CYCLES + MIX_CYCLES + 6;
    localparam logic [`INSTR_W-1:0] SYNC_WORD = 32'h0000_000f;

    logic                clk = 1'b0;
    logic                rst;
    logic [`INSTR_W-1:0] instr;
    logic                stall;
    logic                flush;
    exe_ctrl_t           exe;
    mem_ctrl_t           mem;
    flow_ctrl_t          flow;
    wb_ctrl_t            wb;

    exe_ctrl_t  exp_exe;
    mem_ctrl_t  exp_mem;
    flow_ctrl_t exp_flow;
    wb_ctrl_t   exp_wb;

    int err_count   = 0;
    int check_count = 0;
    int test_count  = 0;

    logic [`FUNCT_W-1:0] rfn_tab [16] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26,
                                          6'h27, 6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03, 6'h04,
                                          6'h06, 6'h07};
    logic [`OP_W-1:0]    mem_tab [8]  = '{6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29,
                                          6'h2b};

    decode_stage decode_stage_i (
        .clk(clk), .rst(rst), .instr(instr), .stall(stall), .flush(flush),
        .exe(exe), .mem(mem), .flow(flow), .wb(wb)
    );

    bind decode_stage decode_stage_checker checker_i (
        .clk(clk), .rst(rst), .flush(flush), .exe(exe), .mem(mem), .flow(flow), .wb(wb)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic wb_ctrl_t write_to(input regdst_t dst);
        return '{1'b1, dst, 1'b0};
    endfunction

    // Reference decode straight from the MIPS encodings
    function automatic void ref_decode(input logic [`INSTR_W-1:0] w, output exe_ctrl_t e,
                                       output mem_ctrl_t m, output flow_ctrl_t f,
                                       output wb_ctrl_t b);
        logic [`OP_W-1:0]    op;
        logic [`FUNCT_W-1:0] fn;
        logic [`REG_W-1:0]   rt;
        op = w[31:26];
        fn = w[5:0];
        rt = w[20:16];
        e  = '0;
        m  = '0;
        f  = '0;
        b  = '0;
        case (op)
            6'h00:
            begin
                case (fn)
                    6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b:
                    begin
                        b             = write_to(DST_RD);
                        e.alu_srcb_rt = 1'b1;
                        e.intovf_en   = (fn == 6'h20) || (fn == 6'h22);
                        case (fn)
                            6'h22, 6'h23: e.alu_func = ALU_SUB;
                            6'h24:        e.alu_func = ALU_AND;
                            6'h25:        e.alu_func = ALU_OR;
                            6'h26:        e.alu_func = ALU_XOR;
                            6'h27:        e.alu_func = ALU_NOR;
                            6'h2a:        e.alu_func = ALU_SLT;
                            6'h2b:        e.alu_func = ALU_SLTU;
                            default:      e.alu_func = ALU_ADD;
                        endcase
                    end
                    6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07:
                    begin
                        b             = write_to(DST_RD);
                        e.out_sel     = OUT_SFT;
                        e.sft_srcb_rs = fn[2];    // Variable forms
                        case (fn[1:0])
                            2'b00:   e.sft_func = SFT_SLL;
                            2'b10:   e.sft_func = SFT_SRL;
                            default: e.sft_func = SFT_SRA;
                        endcase
                    end
                    6'h08:
                    begin
                        f.isjump = 1'b1;
                        f.jump   = JMP_JR;
                    end
                    6'h09:
                    begin
                        f.isjump = 1'b1;
                        f.jump   = JMP_JALR;
                        f.link   = 1'b1;
                        b        = write_to(DST_RD);
                    end
                    6'h0c:   f.syscall = 1'b1;
                    6'h0d:   f.brk = 1'b1;
                    6'h0f:   ;    // SYNC
                    default: b.reserved = 1'b1;
                endcase
            end
            6'h01:
            begin
                case (rt)
                    5'h00, 5'h01, 5'h10, 5'h11:
                    begin
                        f.isbranch = 1'b1;
                        f.link     = rt[4];    // AL forms
                        case (rt)
                            5'h00:   f.branch = BR_BLTZ;
                            5'h01:   f.branch = BR_BGEZ;
                            5'h10:   f.branch = BR_BLTZAL;
                            default: f.branch = BR_BGEZAL;
                        endcase
                        if (rt[4])
                            b = write_to(DST_RA);
                    end
                    default: b.reserved = 1'b1;
                endcase
            end
            6'h02, 6'h03:
            begin
                f.isjump = 1'b1;
                f.jump   = op[0] ? JMP_JAL : JMP_J;
                f.link   = op[0];
                if (op[0])
                    b = write_to(DST_RA);
            end
            6'h04, 6'h05, 6'h06, 6'h07:
            begin
                f.isbranch = 1'b1;
                case (op[1:0])
                    2'b00:   f.branch = BR_BEQ;
                    2'b01:   f.branch = BR_BNE;
                    2'b10:   f.branch = BR_BLEZ;
                    default: f.branch = BR_BGTZ;
                endcase
            end
            6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e:
            begin
                b           = write_to(DST_RT);
                e.imm_sign  = !op[2];    // ADDI to SLTIU
                e.intovf_en = (op == 6'h08);
                case (op[2:0])
                    3'b010:  e.alu_func = ALU_SLT;
                    3'b011:  e.alu_func = ALU_SLTU;
                    3'b100:  e.alu_func = ALU_AND;
                    3'b101:  e.alu_func = ALU_OR;
                    3'b110:  e.alu_func = ALU_XOR;
                    default: e.alu_func = ALU_ADD;
                endcase
            end
            6'h0f:
            begin
                b          = write_to(DST_RT);
                e.out_sel  = OUT_SFT;
                e.sft_func = SFT_LUI;
            end
            6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2b:
            begin
                e.alu_func   = ALU_ADD;
                e.imm_sign   = 1'b1;
                m.memreq     = 1'b1;
                m.memwr      = op[3];    // Stores from 0x28
                m.memtoreg   = !op[3];
                m.rdata_sign = !op[3] && !op[2];
                case (op[1:0])
                    2'b00:   m.size = SZ_BYTE;
                    2'b01:   m.size = SZ_HALF;
                    default: m.size = SZ_WORD;
                endcase
                if (!op[3])
                    b = write_to(DST_RT);
            end
            default: b.reserved = 1'b1;
        endcase
    endfunction

    function automatic logic [`INSTR_W-1:0] gen_instr(input int kind);
        logic [`INSTR_W-1:0] r;
        int                  pick;
        r = $urandom;
        case (kind)
            0: return {6'h00, r[25:6], rfn_tab[4'($urandom_range(0, 15))]};
            1: return {6'(8 + $urandom_range(0, 7)), r[25:0]};
            2: return {mem_tab[3'($urandom_range(0, 7))], r[25:0]};
            3:
            begin
                pick = $urandom_range(0, 11);
                case (pick)
                    0, 1, 2, 3, 4, 5: return {6'(2 + pick), r[25:0]};
                    6:       return {6'h01, r[25:21], 5'h00, r[15:0]};
                    7:       return {6'h01, r[25:21], 5'h01, r[15:0]};
                    8:       return {6'h01, r[25:21], 5'h10, r[15:0]};
                    9:       return {6'h01, r[25:21], 5'h11, r[15:0]};
                    10:      return {6'h00, r[25:6], 6'h08};
                    default: return {6'h00, r[25:6], 6'h09};
                endcase
            end
            default:
            begin
                pick = $urandom_range(0, 9);
                case (pick)
                    3:       return {6'h00, r[25:6], 6'h18};             // MULT
                    4:       return {6'h10, 5'h00, r[20:0]};             // MFC0
                    5:       return {6'h22, r[25:0]};                    // LWL
                    6:       return {6'h1c, r[25:6], 6'h02};             // MUL
                    7:       return {6'h00, r[25:6], 6'h0d};             // BREAK
                    8:       return {6'h00, r[25:6], 6'h0c};             // SYSCALL
                    9:       return {6'h00, r[25:6], 5'b00101, r[0]};    // MOVZ, MOVN
                    default: return r;
                endcase
            end
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] want);
        err_count++;
        $display("error at %0t: %s control is %h, expected %h", $time, name, got, want);
    endtask

    task automatic step(input logic [`INSTR_W-1:0] w, input logic s, input logic f,
                        input logic r);
        @(posedge clk);
        if (rst || flush)    // Values seen by this edge
        begin
            exp_exe  = '0;
            exp_mem  = '0;
            exp_flow = '0;
            exp_wb   = '0;
        end
        else if (!stall)
            ref_decode(instr, exp_exe, exp_mem, exp_flow, exp_wb);
        instr <= w;
        stall <= s;
        flush <= f;
        rst   <= r;
        @(negedge clk);
        check_count++;
        if (exe !== exp_exe)
            report_mismatch("exe", 16'(exe), 16'(exp_exe));
        if (mem !== exp_mem)
            report_mismatch("mem", 16'(mem), 16'(exp_mem));
        if (flow !== exp_flow)
            report_mismatch("flow", 16'(flow), 16'(exp_flow));
        if (wb !== exp_wb)
            report_mismatch("wb", 16'(wb), 16'(exp_wb));
    endtask

    task automatic run_test(input string name, input int kind, input int cycles,
                            input logic use_sf);
        int   start_err;
        int   k;
        logic s;
        logic f;
        start_err = err_count;
        for (int i = 0; i < cycles; i++)
        begin
            k = (kind > 4) ? int'($urandom_range(0, 4)) : kind;
            s = use_sf && ($urandom_range(0, 3) == 0);
            f = use_sf && ($urandom_range(0, 7) == 0);
            step(gen_instr(k), s, f, 1'b0);
        end
        step(SYNC_WORD, 1'b0, 1'b0, 1'b0);    // Lets the last word reach the outputs
        test_count++;
        $display("test %s: %0d cycles, %0d failures", name, cycles, err_count - start_err);
    endtask

    initial
    begin
        void'($urandom(SEED));
        rst   = 1'b1;
        instr = '0;
        stall = 1'b0;
        flush = 1'b0;
        step($urandom, 1'b0, 1'b0, 1'b1);
        step($urandom, 1'b0, 1'b0, 1'b0);
        if ({exe, mem, flow, wb} !== '0)
        begin
            err_count++;
            $display("error at %0t: control outputs not zero after reset", $time);
        end
        test_count++;
        $display("test reset: 2 cycles, %0d failures", err_count);
        run_test("r_type", 0, RALU_CYCLES, 1'b0);
        run_test("immediate", 1, IMM_CYCLES, 1'b0);
        run_test("load_store", 2, MEM_CYCLES, 1'b0);
        run_test("branch_jump", 3, FLOW_CYCLES, 1'b0);
        run_test("reserved_trap", 4, RSV_CYCLES, 1'b0);
        run_test("stall_flush", 5, MIX_CYCLES, 1'b1);
        $display("summary: %0d tests, %0d checks, %0d failures, %0d assertion failures",
                 test_count, check_count, err_count, decode_stage_i.checker_i.fail_count);
        if (err_count == 0 && decode_stage_i.checker_i.fail_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial
    begin
        #((TOTAL_CYCLES + 20) * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", TOTAL_CYCLES + 20);
        $display("Errors found");
        $finish;
    end

endmodule

/* list.f */
+incdir+hdl
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/instr_classifier.sv
hdl/exe_decoder.sv
hdl/mem_decoder.sv
hdl/flow_decoder.sv
hdl/ctrl_stage_reg.sv
hdl/decode_stage.sv
test/decode_stage_checker.sv
test/decode_stage_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Errors found
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+10000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi; \
	if [ $$status -ne 0 ]; then echo "Simulator exited with status $$status"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
